//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = prc_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/prc_mem_model.sv
module prc_mem_model import prc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        bus_request,
    input  logic        read,
    input  logic        write,
    input  logic [23:0] bus_address_out,
    input  logic [7:0]  bus_data_out,
    output logic        bus_ack,
    output logic        rd_valid,
    output logic [7:0]  rdata
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] ram [0:65535];  // Decoded on the low 16 address bits
    int         lcd_cmd_writes;
    int         lcd_data_writes;
    integer     seed;
    logic       lcd_port;

    assign lcd_port = (bus_address_out == LCD_CMD) || (bus_address_out == LCD_DATA);

    initial
    begin
        seed     = 14816;
        bus_ack  = 1'b0;
        rd_valid = 1'b0;
        rdata    = 8'h00;
        // Tile map, tile data and framebuffer all start out random
        for (int i = 0; i < 65536; i++)
            ram[i] = 8'($random(seed));
    end

    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            bus_ack         <= 1'b0;
            rd_valid        <= 1'b0;
            rdata           <= 8'h00;
            lcd_cmd_writes  <= 0;
            lcd_data_writes <= 0;
        end
        else
        begin
            bus_ack  <= bus_request;  // Grant one cycle after the request
            rd_valid <= read;         // Owns bus_data_in in the data cycle
            if (read)
                rdata <= ram[bus_address_out[15:0]];
            if (write && bus_address_out == LCD_CMD)
                lcd_cmd_writes <= lcd_cmd_writes + 1;
            if (write && bus_address_out == LCD_DATA)
                lcd_data_writes <= lcd_data_writes + 1;
        end
    end

    always @(posedge clk)
    begin
        if (!reset && write && !lcd_port)
            ram[bus_address_out[15:0]] <= bus_data_out;
    end

endmodule

//--- dv/prc_tb.sv
module prc_tb import prc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          LINE_CYCLES  = 64;
    localparam int          FRAME_CYCLES = 66 * LINE_CYCLES;
    localparam int          RENDERS      = 2;
    localparam int          PAGE_WRITES  = 3 + FB_COLS;  // Three commands, then the columns
    localparam int          COPY_WRITES  = FB_PAGES * PAGE_WRITES;
    localparam logic [23:0] TILE_BASE    = 24'h004000;
    // Six frames of rate test, three active frames in six per render, four spare
    localparam int          CYCLE_LIMIT  = (6 + RENDERS * 6 + 4) * FRAME_CYCLES;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        bus_write = 1'b0;
    logic        bus_read = 1'b0;
    logic [23:0] bus_address_in = '0;
    logic [7:0]  cpu_data = '0;
    logic [7:0]  bus_data_in;
    logic [7:0]  bus_data_out;
    logic [23:0] bus_address_out;
    logic        write;
    logic        read;
    logic        bus_request;
    logic        bus_ack;
    logic        irq_copy_complete;
    logic        irq_render_done;
    logic        mem_drive;
    logic [7:0]  mem_rdata;

    logic        rd_check = 1'b0;
    logic [7:0]  rd_expect = '0;
    logic        rate_check = 1'b0;
    logic        quiet_check = 1'b0;   // Mode off, bus must stay idle
    logic        render_phase = 1'b0;  // High when the next wrap ends an active frame
    logic [7:0]  prev_count = '0;
    logic        wrap_now;
    logic        fb_write;
    logic        lcd_write;
    int          wraps = 0;
    int          lcd_idx = 0;
    int          data_count = 0;
    int          copies = 0;
    int          cycles = 0;
    int          check_errors = 0;
    int          other_errors = 0;
    integer      seed = 14816;

    always #20 clk = ~clk;

    assign bus_data_in = mem_drive ? mem_rdata : cpu_data;
    assign fb_write    = write && bus_address_out >= FB_BASE
                         && bus_address_out < FB_BASE + 24'(FB_PAGES * FB_COLS);
    assign lcd_write   = write && (bus_address_out == LCD_CMD || bus_address_out == LCD_DATA);
    assign wrap_now    = prev_count == 8'(LINE_LAST) && bus_data_out == 8'h01;

    prc_top #(.LINE_CYCLES(LINE_CYCLES)) uut (.clk, .reset, .bus_write, .bus_read,
        .bus_address_in, .bus_data_in, .bus_data_out, .bus_address_out, .write, .read,
        .bus_request, .bus_ack, .irq_copy_complete, .irq_render_done);

    prc_mem_model mem_model (.clk, .reset, .bus_request, .read, .write, .bus_address_out,
        .bus_data_out, .bus_ack, .rd_valid(mem_drive), .rdata(mem_rdata));

    task automatic log_error(input string msg);
        check_errors++;
        $display("[ERROR] %0t ns %s", $time, msg);
    endtask

    // Byte that a framebuffer address should receive from the tile map
    function automatic logic [7:0] tile_pixel(input logic [23:0] addr);
        int off;
        int page;
        int col;
        int idx;
        off  = int'(addr - FB_BASE);
        page = off / FB_COLS;
        col  = off % FB_COLS;
        idx  = int'(mem_model.ram[16'(int'(TILEMAP_BASE) + page * MAP_PITCH + col / 8)]);
        return mem_model.ram[16'(int'(TILE_BASE) + idx * 8 + col % 8)];
    endfunction

    function automatic logic [23:0] lcd_addr_at(input int n);
        return (n % PAGE_WRITES < 3) ? LCD_CMD : LCD_DATA;
    endfunction

    function automatic logic [7:0] lcd_data_at(input int n);
        int page;
        int pos;
        page = n / PAGE_WRITES;
        pos  = n % PAGE_WRITES;
        case (pos)
            0:       return 8'h10;
            1:       return 8'h00;
            2:       return 8'hB0 + 8'(page);
            default: return mem_model.ram[16'(int'(FB_BASE) + page * FB_COLS + pos - 3)];
        endcase
    endfunction

    task automatic cpu_write(input logic [23:0] addr, input logic [7:0] data);
        @(posedge clk);
        bus_write      <= 1'b1;
        bus_address_in <= addr;
        cpu_data       <= data;
        @(posedge clk);
        bus_write <= 1'b0;
    endtask

    task automatic write_and_read_back(input logic [23:0] addr, input logic [7:0] mask);
        logic [7:0] data;
        data = 8'($random(seed));
        cpu_write(addr, data);
        rd_check  <= 1'b1;
        rd_expect <= data & mask;
        @(posedge clk);
        rd_check <= 1'b0;
    endtask

    always @(posedge clk)
    begin
        cycles     <= cycles + 1;
        prev_count <= bus_data_out;
        if (lcd_write)
        begin
            lcd_idx <= (lcd_idx == COPY_WRITES - 1) ? 0 : lcd_idx + 1;
            if (bus_address_out == LCD_DATA)
                data_count <= data_count + 1;
        end
        if (irq_copy_complete)
        begin
            data_count <= 0;
            copies     <= copies + 1;
        end
        if (rate_check && wrap_now)
        begin
            wraps        <= wraps + 1;
            render_phase <= !render_phase;
        end
    end

    reg_readback: assert property (@(posedge clk) disable iff (reset)
        rd_check |-> bus_data_out == rd_expect)
        else log_error("register read back a wrong value");

    fb_pixel: assert property (@(posedge clk) disable iff (reset)
        fb_write |-> bus_data_out == tile_pixel(bus_address_out))
        else log_error("framebuffer write does not match the tile map");

    lcd_order: assert property (@(posedge clk) disable iff (reset)
        lcd_write |-> bus_address_out == lcd_addr_at(lcd_idx)
                      && bus_data_out == lcd_data_at(lcd_idx))
        else log_error("LCD write has the wrong port or data");

    copy_irq: assert property (@(posedge clk) disable iff (reset)
        irq_copy_complete |-> data_count == FB_PAGES * FB_COLS && lcd_idx == 0)
        else log_error("copy interrupt not after the last LCD data write");

    render_rate: assert property (@(posedge clk) disable iff (reset)
        rate_check && wrap_now |-> irq_render_done == render_phase)
        else log_error("render interrupt does not follow the one in two divider");

    render_at_wrap: assert property (@(posedge clk) disable iff (reset)
        rate_check && irq_render_done |-> wrap_now)
        else log_error("render interrupt away from a frame end");

    bus_quiet: assert property (@(posedge clk) disable iff (reset)
        quiet_check |-> !bus_request && !read && !write)
        else log_error("bus activity with rendering switched off");

    always @(posedge clk)
    begin
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles with %0d of %0d frame copies done",
                     cycles, copies, RENDERS);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial
    begin
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        write_and_read_back(REG_MODE, 8'h3F);
        write_and_read_back(REG_RATE, 8'h0F);
        write_and_read_back(REG_MAP_BASE_LO, 8'hF8);
        write_and_read_back(REG_MAP_BASE_MI, 8'hFF);
        write_and_read_back(REG_MAP_BASE_HI, 8'h1F);
        write_and_read_back(REG_SCROLL_Y, 8'h7F);
        write_and_read_back(REG_SCROLL_X, 8'h7F);
        write_and_read_back(REG_SPR_BASE_LO, 8'hC0);
        write_and_read_back(REG_SPR_BASE_MI, 8'hFF);
        write_and_read_back(REG_SPR_BASE_HI, 8'h1F);
        write_and_read_back(24'h00208B, 8'h00);
        write_and_read_back(24'h00207F, 8'h00);
        write_and_read_back(24'h000000, 8'h00);

        // Rendering off, rate select 4 renders one frame in two
        cpu_write(REG_MODE, 8'h00);
        cpu_write(REG_RATE, 8'h08);
        bus_address_in <= REG_COUNTER;
        rate_check     <= 1'b1;
        quiet_check    <= 1'b1;
        while (wraps < 4)
            @(posedge clk);
        rate_check  <= 1'b0;
        quiet_check <= 1'b0;

        cpu_write(REG_MAP_BASE_LO, TILE_BASE[7:0]);
        cpu_write(REG_MAP_BASE_MI, TILE_BASE[15:8]);
        cpu_write(REG_MAP_BASE_HI, TILE_BASE[23:16]);
        cpu_write(REG_MODE, 8'h0A);  // Map draw and frame copy
        while (copies < RENDERS)
            @(posedge clk);
        repeat (4) @(posedge clk);

        if (mem_model.lcd_data_writes != RENDERS * FB_PAGES * FB_COLS)
        begin
            other_errors++;
            $display("[ERROR] %0t ns The LCD received %0d data writes over %0d frame copies",
                     $time, mem_model.lcd_data_writes, copies);
        end
        if (mem_model.lcd_cmd_writes != RENDERS * FB_PAGES * 3)
        begin
            other_errors++;
            $display("[ERROR] %0t ns The LCD received %0d command writes over %0d frame copies",
                     $time, mem_model.lcd_cmd_writes, copies);
        end

        $display("Assertion errors %0d, other errors %0d, frames tracked %0d, copies %0d",
                 check_errors, other_errors, wraps, copies);
        if (check_errors == 0 && other_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- list.f
src/prc_pkg.sv
src/prc_regs.sv
src/prc_frame_timer.sv
src/prc_control.sv
src/prc_map_engine.sv
src/prc_frame_copy.sv
src/prc_bus_master.sv
src/prc_top.sv
dv/prc_mem_model.sv
dv/prc_tb.sv

//--- src/prc_bus_master.sv
module prc_bus_master import prc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        bus_ack,
    input  mem_req_t    map_req,
    input  mem_req_t    copy_req,
    input  logic [7:0]  bus_data_in,
    output mem_rsp_t    rsp,
    output logic [23:0] bus_address_out,
    output logic [7:0]  bus_data_out,
    output logic        read,
    output logic        write
);

    mem_req_t sel;
    logic     phase;   // 0 address cycle, 1 data cycle
    logic     launch;

    assign sel    = map_req.valid ? map_req : copy_req;
    assign launch = !phase && bus_ack && sel.valid;  // No new cycle without the grant

    assign bus_address_out = sel.addr;
    assign bus_data_out    = sel.wdata;
    assign read            = launch && !sel.write;
    assign write           = launch && sel.write;

    // Read data arrives in the second cycle
    assign rsp.done  = phase;
    assign rsp.rdata = bus_data_in;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            phase <= 1'b0;
        else if (phase)
            phase <= 1'b0;
        else if (launch)
            phase <= 1'b1;
    end

    rw_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && write));

endmodule

//--- src/prc_control.sv
module prc_control import prc_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  prc_cfg_t   cfg,
    input  logic       line_tick,
    input  logic       frame_end,
    input  logic       active_frame,
    input  logic [6:0] line_count,
    input  logic       bus_ack,
    input  logic       map_done,
    input  logic       copy_done,
    output logic       map_start,
    output logic       copy_start,
    output logic       bus_request,
    output logic       irq_render_done,
    output logic       irq_copy_complete
);

    prc_state_e state;
    logic       pending;  // Request raised, stage not yet started
    logic       kick;

    assign kick = line_tick && active_frame && (line_count >= LINE_ACTIVE_FIRST)
                  && (cfg.mode[1] || cfg.mode[3]) && !bus_request;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state             <= IDLE;
            pending           <= 1'b0;
            bus_request       <= 1'b0;
            map_start         <= 1'b0;
            copy_start        <= 1'b0;
            irq_render_done   <= 1'b0;
            irq_copy_complete <= 1'b0;
        end
        else
        begin
            map_start         <= 1'b0;
            copy_start        <= 1'b0;
            irq_render_done   <= 1'b0;
            irq_copy_complete <= 1'b0;

            if (frame_end && active_frame)
            begin
                bus_request     <= 1'b0;
                pending         <= 1'b0;
                irq_render_done <= 1'b1;
            end
            else if (kick)
            begin
                bus_request <= 1'b1;
                pending     <= (state == IDLE);  // An unfinished stage just resumes
            end

            case (state)
                IDLE:
                    if (pending && bus_ack)
                    begin
                        pending <= 1'b0;
                        if (cfg.mode[1])
                        begin
                            map_start <= 1'b1;
                            state     <= MAP_DRAW;
                        end
                        else if (cfg.mode[3])
                        begin
                            copy_start <= 1'b1;
                            state      <= FRAME_COPY;
                        end
                    end
                MAP_DRAW:
                    if (map_done)
                    begin
                        copy_start <= cfg.mode[3];
                        state      <= cfg.mode[3] ? FRAME_COPY : IDLE;
                    end
                default:
                    if (copy_done)
                    begin
                        irq_copy_complete <= 1'b1;
                        state             <= IDLE;
                    end
            endcase
        end
    end

    // Only one engine may own the bus at a time
    one_stage_start: assert property (@(posedge clk) disable iff (reset)
        !(map_start && copy_start));

endmodule

//--- src/prc_frame_copy.sv
module prc_frame_copy import prc_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     copy_start,
    input  mem_rsp_t rsp,
    output mem_req_t req,
    output logic     copy_done
);

    copy_step_e step;
    logic       busy;
    logic [2:0] page;
    logic [6:0] col;
    logic [7:0] pixel;  // Framebuffer byte on its way to the LCD
    logic       ack;

    assign ack = busy && rsp.done;

    always_comb
    begin
        req.valid = busy;
        req.write = (step != MEM_READ);
        req.addr  = LCD_CMD;
        req.wdata = 8'h00;
        case (step)
            COLUMN_SET1: req.wdata = 8'h10;
            PAGE_SET:    req.wdata = {5'b10110, page};  // 0xB0 + page
            MEM_READ:    req.addr  = FB_BASE + 24'(page) * 24'(FB_COLS) + 24'(col);
            LCD_WRITE:
            begin
                req.addr  = LCD_DATA;
                req.wdata = pixel;
            end
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            step      <= COLUMN_SET1;
            busy      <= 1'b0;
            page      <= '0;
            col       <= '0;
            copy_done <= 1'b0;
        end
        else
        begin
            copy_done <= 1'b0;
            if (copy_start)
            begin
                busy <= 1'b1;
                step <= COLUMN_SET1;
                page <= '0;
                col  <= '0;
            end
            else if (ack)
            begin
                case (step)
                    COLUMN_SET1: step <= COLUMN_SET2;
                    COLUMN_SET2: step <= PAGE_SET;
                    PAGE_SET:    step <= MEM_READ;
                    MEM_READ:    step <= LCD_WRITE;
                    default:
                    begin
                        step <= MEM_READ;
                        col  <= col + 7'd1;
                        if (col == 7'(FB_COLS - 1))
                        begin
                            step <= COLUMN_SET1;
                            col  <= '0;
                            page <= page + 3'd1;
                            if (page == 3'(FB_PAGES - 1))
                            begin
                                busy      <= 1'b0;
                                copy_done <= 1'b1;
                            end
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ack && step == MEM_READ)
            pixel <= rsp.rdata;
    end

endmodule

//--- src/prc_frame_timer.sv
module prc_frame_timer import prc_pkg::*;
#(
    parameter int LINE_CYCLES = 855
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] rate_select,
    output logic       line_tick,
    output logic       frame_end,
    output logic       active_frame,
    output logic [6:0] line_count
);

    localparam int OSC_W = $clog2(LINE_CYCLES);

    logic [OSC_W-1:0] osc;
    logic [3:0]       frame_count;
    logic [3:0]       rate_match;
    logic [2:0]       rate_prev;

    always_comb
    begin
        case (rate_select)
            3'd0:    rate_match = 4'd2;   // 1 in 3
            3'd1:    rate_match = 4'd5;
            3'd2:    rate_match = 4'd8;
            3'd3:    rate_match = 4'd11;  // 1 in 12
            3'd4:    rate_match = 4'd1;
            3'd5:    rate_match = 4'd3;
            3'd6:    rate_match = 4'd5;
            default: rate_match = 4'd7;
        endcase
    end

    assign line_tick    = (osc == OSC_W'(LINE_CYCLES - 1));
    assign frame_end    = line_tick && (line_count == LINE_LAST);
    assign active_frame = (frame_count == rate_match);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            osc         <= '0;
            line_count  <= 7'd1;
            frame_count <= '0;
            rate_prev   <= '0;
        end
        else
        begin
            osc       <= line_tick ? '0 : osc + 1'b1;
            rate_prev <= rate_select;
            if (line_tick)
                line_count <= (line_count == LINE_LAST) ? 7'd1 : line_count + 7'd1;
            // Changing the divider restarts the frame count
            if (rate_select != rate_prev)
                frame_count <= '0;
            else if (frame_end)
                frame_count <= active_frame ? 4'd0 : frame_count + 4'd1;
        end
    end

    line_in_range: assert property (@(posedge clk) disable iff (reset)
        line_count <= LINE_LAST);

endmodule

//--- src/prc_map_engine.sv
module prc_map_engine import prc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        map_start,
    input  logic [23:0] map_base,
    input  mem_rsp_t    rsp,
    output mem_req_t    req,
    output logic        map_done
);

    map_step_e  step;
    logic       busy;
    logic [2:0] page;
    logic [6:0] col;
    logic [7:0] tile_idx;
    logic [7:0] tile_byte;
    logic       ack;

    assign ack = busy && rsp.done;

    always_comb
    begin
        req.valid = busy;
        req.write = (step == FB_WRITE);
        req.wdata = tile_byte;
        case (step)
            TILE_INDEX: req.addr = TILEMAP_BASE + 24'(page) * 24'(MAP_PITCH) + 24'(col[6:3]);
            TILE_DATA:  req.addr = map_base + {13'b0, tile_idx, 3'b0} + 24'(col[2:0]);
            default:    req.addr = FB_BASE + 24'(page) * 24'(FB_COLS) + 24'(col);
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            step     <= TILE_INDEX;
            busy     <= 1'b0;
            page     <= '0;
            col      <= '0;
            map_done <= 1'b0;
        end
        else
        begin
            map_done <= 1'b0;
            if (map_start)
            begin
                busy <= 1'b1;
                step <= TILE_INDEX;
                page <= '0;
                col  <= '0;
            end
            else if (ack)
            begin
                case (step)
                    TILE_INDEX: step <= TILE_DATA;
                    TILE_DATA:  step <= FB_WRITE;
                    default:
                    begin
                        step <= TILE_INDEX;
                        col  <= col + 7'd1;
                        if (col == 7'(FB_COLS - 1))
                        begin
                            col  <= '0;
                            page <= page + 3'd1;
                            if (page == 3'(FB_PAGES - 1))
                            begin
                                busy     <= 1'b0;
                                map_done <= 1'b1;
                            end
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ack && step == TILE_INDEX)
            tile_idx <= rsp.rdata;
        if (ack && step == TILE_DATA)
            tile_byte <= rsp.rdata;
    end

endmodule

//--- src/prc_pkg.sv
package prc_pkg;

    typedef enum logic [1:0]
    {
        IDLE,
        MAP_DRAW,
        FRAME_COPY
    } prc_state_e;

    typedef enum logic [2:0]
    {
        COLUMN_SET1,
        COLUMN_SET2,
        PAGE_SET,
        MEM_READ,
        LCD_WRITE
    } copy_step_e;

    typedef enum logic [1:0]
    {
        TILE_INDEX,
        TILE_DATA,
        FB_WRITE
    } map_step_e;

    // CPU register map
    localparam logic [23:0] REG_MODE        = 24'h2080;
    localparam logic [23:0] REG_RATE        = 24'h2081;
    localparam logic [23:0] REG_MAP_BASE_LO = 24'h2082;
    localparam logic [23:0] REG_MAP_BASE_MI = 24'h2083;
    localparam logic [23:0] REG_MAP_BASE_HI = 24'h2084;
    localparam logic [23:0] REG_SCROLL_Y    = 24'h2085;
    localparam logic [23:0] REG_SCROLL_X    = 24'h2086;
    localparam logic [23:0] REG_SPR_BASE_LO = 24'h2087;
    localparam logic [23:0] REG_SPR_BASE_MI = 24'h2088;
    localparam logic [23:0] REG_SPR_BASE_HI = 24'h2089;
    localparam logic [23:0] REG_COUNTER     = 24'h208A;

    localparam logic [23:0] FB_BASE      = 24'h1000;
    localparam logic [23:0] TILEMAP_BASE = 24'h1360;
    localparam logic [23:0] LCD_CMD      = 24'h20FE;
    localparam logic [23:0] LCD_DATA     = 24'h20FF;

    localparam int FB_PAGES  = 8;
    localparam int FB_COLS   = 96;
    localparam int MAP_PITCH = 12;  // Tiles per map row

    localparam logic [6:0] LINE_ACTIVE_FIRST = 7'h18;
    localparam logic [6:0] LINE_LAST         = 7'h42;

    typedef struct packed
    {
        logic [5:0]  mode;
        logic [2:0]  rate_select;
        logic [23:0] map_base;
    } prc_cfg_t;

    typedef struct packed
    {
        logic        valid;
        logic        write;
        logic [23:0] addr;
        logic [7:0]  wdata;
    } mem_req_t;

    typedef struct packed
    {
        logic       done;
        logic [7:0] rdata;
    } mem_rsp_t;

endpackage

//--- src/prc_regs.sv
module prc_regs import prc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        bus_write,
    input  logic [23:0] bus_address_in,
    input  logic [7:0]  bus_data_in,
    input  logic [6:0]  line_count,
    output prc_cfg_t    cfg,
    output logic [7:0]  reg_rdata
);

    logic [5:0]  mode;
    logic [3:0]  rate;
    logic [23:0] map_base;
    logic [23:0] spr_base;  // Kept as storage only
    logic [6:0]  scroll_y;
    logic [6:0]  scroll_x;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            mode     <= '0;
            rate     <= '0;
            map_base <= '0;
            spr_base <= '0;
            scroll_y <= '0;
            scroll_x <= '0;
        end
        else if (bus_write)
        begin
            case (bus_address_in)
                REG_MODE:        mode            <= bus_data_in[5:0];
                REG_RATE:        rate            <= bus_data_in[3:0];
                REG_MAP_BASE_LO: map_base[7:3]   <= bus_data_in[7:3];  // Tiles are 8-byte aligned
                REG_MAP_BASE_MI: map_base[15:8]  <= bus_data_in;
                REG_MAP_BASE_HI: map_base[20:16] <= bus_data_in[4:0];
                REG_SCROLL_Y:    scroll_y        <= bus_data_in[6:0];
                REG_SCROLL_X:    scroll_x        <= bus_data_in[6:0];
                REG_SPR_BASE_LO: spr_base[7:6]   <= bus_data_in[7:6];
                REG_SPR_BASE_MI: spr_base[15:8]  <= bus_data_in;
                REG_SPR_BASE_HI: spr_base[20:16] <= bus_data_in[4:0];
                default:
                begin
                end
            endcase
        end
    end

    assign cfg = '{mode: mode, rate_select: rate[3:1], map_base: map_base};

    always_comb
    begin
        case (bus_address_in)
            REG_MODE:        reg_rdata = {2'b0, mode};
            REG_RATE:        reg_rdata = {4'b0, rate};
            REG_MAP_BASE_LO: reg_rdata = map_base[7:0];
            REG_MAP_BASE_MI: reg_rdata = map_base[15:8];
            REG_MAP_BASE_HI: reg_rdata = map_base[23:16];
            REG_SCROLL_Y:    reg_rdata = {1'b0, scroll_y};
            REG_SCROLL_X:    reg_rdata = {1'b0, scroll_x};
            REG_SPR_BASE_LO: reg_rdata = spr_base[7:0];
            REG_SPR_BASE_MI: reg_rdata = spr_base[15:8];
            REG_SPR_BASE_HI: reg_rdata = spr_base[23:16];
            REG_COUNTER:     reg_rdata = {1'b0, line_count};
            default:         reg_rdata = 8'h00;
        endcase
    end

    // Map engine adds tile offsets into the low bits
    map_base_aligned: assert property (@(posedge clk) disable iff (reset)
        cfg.map_base[2:0] == 3'b000);

endmodule

//--- src/prc_top.sv
module prc_top import prc_pkg::*;
#(
    parameter int LINE_CYCLES = 855
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic        bus_write,
    input  logic        bus_read,       // Unused, reads are combinational
    input  logic [23:0] bus_address_in,
    input  logic [7:0]  bus_data_in,
    output logic [7:0]  bus_data_out,
    output logic [23:0] bus_address_out,
    output logic        write,
    output logic        read,
    output logic        bus_request,
    input  logic        bus_ack,
    output logic        irq_copy_complete,
    output logic        irq_render_done
);

    prc_cfg_t   cfg;
    mem_req_t   map_req;
    mem_req_t   copy_req;
    mem_rsp_t   mem_rsp;
    logic [6:0] line_count;
    logic [7:0] reg_rdata;
    logic [7:0] master_data;
    logic       line_tick;
    logic       frame_end;
    logic       active_frame;
    logic       map_start;
    logic       map_done;
    logic       copy_start;
    logic       copy_done;

    // Master write data while the bus is granted, register reads otherwise
    assign bus_data_out = bus_ack ? master_data : reg_rdata;

    prc_regs u_regs (.clk, .reset, .bus_write, .bus_address_in, .bus_data_in,
        .line_count, .cfg, .reg_rdata);

    prc_frame_timer #(.LINE_CYCLES(LINE_CYCLES)) u_timer (.clk, .reset,
        .rate_select(cfg.rate_select), .line_tick, .frame_end, .active_frame, .line_count);

    prc_control u_control (.clk, .reset, .cfg, .line_tick, .frame_end, .active_frame,
        .line_count, .bus_ack, .map_done, .copy_done, .map_start, .copy_start,
        .bus_request, .irq_render_done, .irq_copy_complete);

    prc_map_engine u_map (.clk, .reset, .map_start, .map_base(cfg.map_base),
        .rsp(mem_rsp), .req(map_req), .map_done);

    prc_frame_copy u_copy (.clk, .reset, .copy_start, .rsp(mem_rsp), .req(copy_req),
        .copy_done);

    prc_bus_master u_master (.clk, .reset, .bus_ack, .map_req, .copy_req, .bus_data_in,
        .rsp(mem_rsp), .bus_address_out, .bus_data_out(master_data), .read, .write);

endmodule
